// ==== sources.f ====
cnn_pkg.sv
stream_fifo.sv
cnn_reg_bank.sv
cnn_control.sv
cnn_conv_core.sv
cnn_accel_top.sv
tb_cnn_accel.sv

// ==== Makefile ====
all: obj_dir/Vtb_cnn_accel

obj_dir/Vtb_cnn_accel: sources.f $(wildcard *.sv)
	verilator --binary --timing --assert --top-module tb_cnn_accel -f sources.f

run: obj_dir/Vtb_cnn_accel
	@out="$$(./obj_dir/Vtb_cnn_accel)"; echo "$$out"; echo "$$out" | grep -q "test passed"

clean:
	rm -rf obj_dir

.PHONY: all run clean

// ==== tb_cnn_accel.sv ====
`default_nettype none

module tb_cnn_accel import cnn_pkg::*; ();

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_WAIT} op_t;

    // For OP_WAIT the data field is a mask on the polled register
    typedef struct packed {
        op_t         op;
        logic [2:0]  addr;
        logic [31:0] data;
        logic [31:0] exp_val;
    } step_t;

    localparam int POLL_LIMIT = 100;

    logic     clk;
    logic     rst_n;
    reg_req_t req;
    reg_rsp_t rsp;

    step_t steps[$];
    int    frame_px[$]; // Pixels of the frame being built
    bit    table_ready;

    cnn_accel_top uut (.clk, .rst_n, .req, .rsp);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic void add_write(logic [2:0] addr, logic [31:0] data);
        steps.push_back('{op: OP_WRITE, addr: addr, data: data, exp_val: '0});
    endfunction

    function automatic void add_read(logic [2:0] addr, logic [31:0] exp_val);
        steps.push_back('{op: OP_READ, addr: addr, data: '0, exp_val: exp_val});
    endfunction

    function automatic void add_wait(logic [2:0] addr, logic [31:0] mask, logic [31:0] exp_val);
        steps.push_back('{op: OP_WAIT, addr: addr, data: mask, exp_val: exp_val});
    endfunction

    // PIXEL write, then a rising edge on the valid bit
    function automatic void add_pixel(logic [7:0] value, logic last);
        logic [31:0] ctrl;
        ctrl = 32'd1 << CTRL_PIXEL_VALID;
        ctrl[CTRL_FRAME_LAST] = last;
        add_write(REG_PIXEL, {24'd0, value});
        add_write(REG_CTRL, ctrl);
        add_write(REG_CTRL, '0);
    endfunction

    function automatic void add_start();
        add_write(REG_CTRL, (32'd1 << CTRL_CNN_START) | (32'd1 << CTRL_FRAME_START));
        add_write(REG_CTRL, '0);
    endfunction

    // 1-2-1 kernel over x[n-2], x[n-1], x[n], minus 256, then ReLU
    function automatic cnn_result_t conv_model();
        int acc;
        int tap;
        int win;
        acc = 0;
        win = 0;
        for (int n = 2; n < frame_px.size(); n++) begin
            tap = frame_px[n-2] + 2 * frame_px[n-1] + frame_px[n] - 256;
            if (tap > 0) acc += tap;
            win++;
        end
        return '{sum: acc[23:0], windows: win[7:0]};
    endfunction

    function automatic void add_frame(int frames_done);
        add_start();
        foreach (frame_px[i]) add_pixel(8'(frame_px[i]), i == frame_px.size() - 1);
        add_wait(REG_STATUS, 32'h2, 32'h2); // Result flag
        add_read(REG_FRAME_COUNT, 32'(frames_done));
        add_read(REG_RESULT, conv_model());
        add_read(REG_STATUS, '0);
    endfunction

    function automatic void build_table();
        add_read(REG_FRAME_COUNT, '0);
        add_read(REG_ERROR_CODE, ERROR_NONE);
        add_read(REG_STATUS, '0);
        frame_px = '{10, 200, 100, 50, 250, 30};
        add_frame(1);
        frame_px.delete();
        repeat (6) frame_px.push_back(int'($urandom() % 256));
        add_frame(2);
        // Second start lands while the core is busy
        add_start();
        add_write(REG_CTRL, 32'd1 << CTRL_CNN_START);
        add_write(REG_CTRL, '0);
        add_read(REG_ERROR_CODE, ERROR_INVALID_START);
        add_write(REG_CTRL, 32'd1 << CTRL_CNN_RESET);
        add_write(REG_CTRL, '0);
        add_read(REG_ERROR_CODE, ERROR_NONE);
        add_read(REG_STATUS, '0);
        // Idle core, so the fifth pixel finds the FIFO full
        repeat (5) add_pixel(8'($urandom()), 1'b0);
        add_read(REG_ERROR_CODE, ERROR_PIXEL_OVERFLOW);
        add_read(REG_STATUS, 32'h4);
        add_start(); // No last pixel follows
        add_wait(REG_ERROR_CODE, '1, ERROR_CNN_TIMEOUT);
        add_read(REG_STATUS, '0);
    endfunction

    task automatic end_in_failure();
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(string msg);
        $display("Fail at %0t: %s", $time, msg);
        end_in_failure();
    endtask

    task automatic check_word(logic [2:0] addr, logic [31:0] got, logic [31:0] exp_val);
        if (got !== exp_val)
            report_mismatch($sformatf("register %0d read 0x%08h, expected 0x%08h",
                                      addr, got, exp_val));
    endtask

    task automatic check_result(cnn_result_t got, cnn_result_t exp_val);
        if (got !== exp_val)
            report_mismatch($sformatf("result sum %0d windows %0d, expected sum %0d windows %0d",
                                      got.sum, got.windows, exp_val.sum, exp_val.windows));
    endtask

    task automatic check_status(logic [2:0] got, logic [2:0] exp_val);
        if (got !== exp_val)
            report_mismatch($sformatf("STATUS bits %03b, expected %03b", got, exp_val));
    endtask

    task automatic bus_write(logic [2:0] addr, logic [31:0] data);
        @(posedge clk);
        req <= '{valid: 1'b1, write: 1'b1, addr: addr, wdata: data};
        @(posedge clk);
        req <= '0;
    endtask

    task automatic bus_read(input logic [2:0] addr, output logic [31:0] data);
        @(posedge clk);
        req <= '{valid: 1'b1, write: 1'b0, addr: addr, wdata: '0};
        @(posedge clk);
        req <= '0;
        @(negedge clk); // Mid response cycle
        if (rsp.valid !== 1'b1) begin
            $display("No read response one cycle after the request to register %0d", addr);
            end_in_failure();
        end
        data = rsp.rdata;
    endtask

    task automatic poll_until(logic [2:0] addr, logic [31:0] mask, logic [31:0] exp_val);
        logic [31:0] rdata;
        int          tries;
        tries = 0;
        do begin
            bus_read(addr, rdata);
            tries++;
        end while ((rdata & mask) !== exp_val && tries < POLL_LIMIT);
        if ((rdata & mask) !== exp_val) begin
            $display("Register %0d did not reach 0x%08h within %0d reads",
                     addr, exp_val, POLL_LIMIT);
            end_in_failure();
        end
    endtask

    task automatic apply_step(step_t st);
        logic [31:0] rdata;
        case (st.op)
            OP_WRITE: bus_write(st.addr, st.data);
            OP_WAIT:  poll_until(st.addr, st.data, st.exp_val);
            default: begin
                bus_read(st.addr, rdata);
                if (st.addr == REG_RESULT)
                    check_result(cnn_result_t'(rdata), cnn_result_t'(st.exp_val));
                else if (st.addr == REG_STATUS)
                    check_status(rdata[2:0], st.exp_val[2:0]);
                else
                    check_word(st.addr, rdata, st.exp_val);
            end
        endcase
    endtask

    // Budget scales with the table length
    initial begin
        wait (table_ready);
        repeat (steps.size() * 200) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the table finished",
                 steps.size() * 200);
        end_in_failure();
    end

    initial begin
        rst_n = 1'b0;
        req   = '0;
        void'($urandom(32'hd200));
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        foreach (steps[i]) apply_step(steps[i]);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cnn_accel_top.sv ====
`default_nettype none

module cnn_accel_top import cnn_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_req_t req,
    output reg_rsp_t rsp
);

    logic [31:0]  ctrl_word;
    logic [31:0]  pixel_word;
    logic [31:0]  frame_count;
    logic [31:0]  error_code;
    cnn_result_t  last_result;
    logic         result_seen;

    logic         pix_in_valid;
    logic         pix_in_ready;
    pixel_beat_t  pix_in_beat;
    logic         pix_out_valid;
    logic         pix_out_ready;
    pixel_beat_t  pix_out_beat;

    logic         res_in_valid;
    logic         res_in_ready;
    cnn_result_t  res_in_data;
    logic         res_out_valid;
    cnn_result_t  res_out_data;

    logic         core_start;
    logic         core_clear;
    core_status_t core_stat;

    cnn_reg_bank u_bank (
        .clk, .rst_n, .req, .rsp,
        .ctrl_word, .pixel_word,
        .core_busy   (core_stat.busy),
        .fifo_full   (!pix_in_ready),
        .frame_count, .error_code, .last_result, .result_seen
    );

    cnn_control u_control (
        .clk, .rst_n, .ctrl_word, .pixel_word,
        .pix_valid   (pix_in_valid),
        .pix_ready   (pix_in_ready),
        .pix_beat    (pix_in_beat),
        .res_valid   (res_out_valid),
        .res_data    (res_out_data),
        .core_start, .core_clear, .core_stat,
        .frame_count, .error_code, .last_result, .result_seen
    );

    stream_fifo #(.payload_t(pixel_beat_t), .DEPTH(PIXEL_FIFO_DEPTH)) u_pix_fifo (
        .clk, .rst_n,
        .in_valid  (pix_in_valid),  .in_ready  (pix_in_ready),  .in_data  (pix_in_beat),
        .out_valid (pix_out_valid), .out_ready (pix_out_ready), .out_data (pix_out_beat)
    );

    cnn_conv_core u_core (
        .clk, .rst_n,
        .start      (core_start),
        .clear      (core_clear),
        .in_valid   (pix_out_valid), .in_ready  (pix_out_ready), .in_beat    (pix_out_beat),
        .out_valid  (res_in_valid),  .out_ready (res_in_ready),  .out_result (res_in_data),
        .status     (core_stat)
    );

    // Control drains every result as it arrives
    stream_fifo #(.payload_t(cnn_result_t), .DEPTH(RESULT_FIFO_DEPTH)) u_res_fifo (
        .clk, .rst_n,
        .in_valid  (res_in_valid),  .in_ready  (res_in_ready), .in_data  (res_in_data),
        .out_valid (res_out_valid), .out_ready (1'b1),         .out_data (res_out_data)
    );

endmodule

`default_nettype wire

// ==== cnn_conv_core.sv ====
`default_nettype none

module cnn_conv_core import cnn_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start,
    input  logic         clear,
    input  logic         in_valid,
    output logic         in_ready,
    input  pixel_beat_t  in_beat,
    output logic         out_valid,
    input  logic         out_ready,
    output cnn_result_t  out_result,
    output core_status_t status
);

    logic             busy;
    logic             hold;    // Result offered, waiting for the FIFO
    logic [1:0]       fill;    // Pixels seen this frame, saturates at 2
    logic [7:0]       tap_d1;  // x[n-1]
    logic [7:0]       tap_d2;  // x[n-2]
    logic [23:0]      sum;
    logic [7:0]       windows;
    logic [TAP_W-1:0] tap_sum;
    logic [TAP_W-1:0] relu;
    logic             take;
    logic             win_full;

    assign in_ready = busy && !hold;
    assign take     = in_valid && in_ready;
    assign win_full = (fill == 2'd2);

    always_comb begin
        tap_sum = KERNEL_W0 * TAP_W'(tap_d2)
                + KERNEL_W1 * TAP_W'(tap_d1)
                + KERNEL_W2 * TAP_W'(in_beat.data);
        relu = (tap_sum > KERNEL_BIAS) ? tap_sum - KERNEL_BIAS : '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            hold    <= 1'b0;
            fill    <= '0;
            sum     <= '0;
            windows <= '0;
        end else if (clear) begin
            busy    <= 1'b0;
            hold    <= 1'b0;
            fill    <= '0;
            sum     <= '0;
            windows <= '0;
        end else if (start) begin
            busy    <= 1'b1;
            hold    <= 1'b0;
            fill    <= '0;
            sum     <= '0;
            windows <= '0;
        end else begin
            if (take) begin
                if (!win_full) begin
                    fill <= fill + 1'b1;
                end else begin
                    sum     <= sum + 24'(relu);
                    windows <= windows + 1'b1;
                end
                if (in_beat.last) hold <= 1'b1; // Sum above already includes this beat
            end
            if (hold && out_ready) begin
                hold <= 1'b0;
                busy <= 1'b0;
            end
        end
    end

    // Shift register for the two previous taps
    always_ff @(posedge clk) begin
        if (take) begin
            tap_d2 <= tap_d1;
            tap_d1 <= in_beat.data;
        end
    end

    assign out_valid  = hold;
    assign out_result = '{sum: sum, windows: windows};
    assign status     = '{busy: busy};

endmodule

`default_nettype wire

// ==== cnn_control.sv ====
`default_nettype none

module cnn_control import cnn_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [31:0]  ctrl_word,
    input  logic [31:0]  pixel_word,
    output logic         pix_valid,
    input  logic         pix_ready,
    output pixel_beat_t  pix_beat,
    input  logic         res_valid,
    input  cnn_result_t  res_data,
    output logic         core_start,
    output logic         core_clear,
    input  core_status_t core_stat,
    output logic [31:0]  frame_count,
    output logic [31:0]  error_code,
    output cnn_result_t  last_result,
    output logic         result_seen
);

    logic start_d, reset_d, pixel_d, fstart_d;
    logic start_pulse, reset_pulse, pixel_pulse, fstart_pulse;
    logic [TIMEOUT_W-1:0] stall_cnt;
    logic timeout_hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_d  <= 1'b0;
            reset_d  <= 1'b0;
            pixel_d  <= 1'b0;
            fstart_d <= 1'b0;
        end else begin
            start_d  <= ctrl_word[CTRL_CNN_START];
            reset_d  <= ctrl_word[CTRL_CNN_RESET];
            pixel_d  <= ctrl_word[CTRL_PIXEL_VALID];
            fstart_d <= ctrl_word[CTRL_FRAME_START];
        end
    end

    // Rising edges, one cycle wide
    assign start_pulse  = ctrl_word[CTRL_CNN_START] && !start_d;
    assign reset_pulse  = ctrl_word[CTRL_CNN_RESET] && !reset_d;
    assign pixel_pulse  = ctrl_word[CTRL_PIXEL_VALID] && !pixel_d;
    assign fstart_pulse = ctrl_word[CTRL_FRAME_START] && !fstart_d;

    assign pix_valid = pixel_pulse;
    assign pix_beat  = '{data: pixel_word[7:0], last: ctrl_word[CTRL_FRAME_LAST]};

    assign timeout_hit = core_stat.busy && (stall_cnt == TIMEOUT_W'(TIMEOUT_CYCLES));

    // Start already resets the window, so frame start alongside it needs no clear
    assign core_start = start_pulse && !core_stat.busy && !reset_pulse;
    assign core_clear = reset_pulse || timeout_hit || (fstart_pulse && !start_pulse);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_cnt   <= '0;
            frame_count <= '0;
            error_code  <= ERROR_NONE;
            result_seen <= 1'b0;
        end else begin
            if (!core_stat.busy || pix_valid || timeout_hit) stall_cnt <= '0;
            else                                             stall_cnt <= stall_cnt + 1'b1;

            if (res_valid) frame_count <= frame_count + 1'b1;
            result_seen <= res_valid;

            // Later checks take priority, reset last
            if (pixel_pulse && !pix_ready)    error_code <= ERROR_PIXEL_OVERFLOW;
            if (start_pulse && core_stat.busy) error_code <= ERROR_INVALID_START;
            if (timeout_hit)                   error_code <= ERROR_CNN_TIMEOUT;
            if (reset_pulse)                   error_code <= ERROR_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) last_result <= res_data;
    end

    // Core goes busy after every start it is given
    a_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        core_start |=> core_stat.busy);

endmodule

`default_nettype wire

// ==== cnn_reg_bank.sv ====
`default_nettype none

module cnn_reg_bank import cnn_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  reg_req_t    req,
    output reg_rsp_t    rsp,
    output logic [31:0] ctrl_word,
    output logic [31:0] pixel_word,
    input  logic        core_busy,
    input  logic        fifo_full,
    input  logic [31:0] frame_count,
    input  logic [31:0] error_code,
    input  cnn_result_t last_result,
    input  logic        result_seen
);

    logic        result_flag; // Sticky until REG_RESULT is read
    logic        rd_req;
    logic        wr_req;
    logic [31:0] rd_mux;

    assign rd_req = req.valid && !req.write;
    assign wr_req = req.valid && req.write;

    always_comb begin
        case (req.addr)
            REG_CTRL:        rd_mux = ctrl_word;
            REG_PIXEL:       rd_mux = pixel_word;
            REG_STATUS:      rd_mux = {29'd0, fifo_full, result_flag, core_busy};
            REG_FRAME_COUNT: rd_mux = frame_count;
            REG_ERROR_CODE:  rd_mux = error_code;
            REG_RESULT:      rd_mux = last_result;
            default:         rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_word   <= '0;
            pixel_word  <= '0;
            result_flag <= 1'b0;
            rsp         <= '0;
        end else begin
            if (wr_req) begin
                case (req.addr)
                    REG_CTRL:  ctrl_word  <= req.wdata;
                    REG_PIXEL: pixel_word <= req.wdata;
                    default:   ; // Read-only or unmapped
                endcase
            end

            // A new result wins over a read in the same cycle
            if (result_seen) begin
                result_flag <= 1'b1;
            end else if (rd_req && req.addr == REG_RESULT) begin
                result_flag <= 1'b0;
            end

            rsp.valid <= rd_req;
            if (rd_req) rsp.rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// ==== stream_fifo.sv ====
`default_nettype none

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            push;
    logic            pop;

    assign in_ready  = (count != CW'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_data;
    end

    // Write pointer never laps the unread head
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> ((count == '0) || (wr_ptr != rd_ptr)));

    // Head entry must hold while the consumer stalls
    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// ==== cnn_pkg.sv ====
`default_nettype none

package cnn_pkg;

    // Register word addresses
    localparam logic [2:0] REG_CTRL        = 3'd0;
    localparam logic [2:0] REG_PIXEL       = 3'd1;
    localparam logic [2:0] REG_STATUS      = 3'd2;
    localparam logic [2:0] REG_FRAME_COUNT = 3'd3;
    localparam logic [2:0] REG_ERROR_CODE  = 3'd4;
    localparam logic [2:0] REG_RESULT      = 3'd5;

    // CTRL bit positions
    localparam int CTRL_CNN_START   = 0;
    localparam int CTRL_CNN_RESET   = 1;
    localparam int CTRL_PIXEL_VALID = 2;
    localparam int CTRL_FRAME_START = 3;
    localparam int CTRL_FRAME_LAST  = 4; // Tags the pixel of the same write as last

    localparam logic [31:0] ERROR_NONE           = 32'd0;
    localparam logic [31:0] ERROR_CNN_TIMEOUT    = 32'd1;
    localparam logic [31:0] ERROR_INVALID_START  = 32'd2;
    localparam logic [31:0] ERROR_PIXEL_OVERFLOW = 32'd3;

    // Tap arithmetic width, 4 * 255 still fits
    localparam int TAP_W = 10;

    localparam logic [TAP_W-1:0] KERNEL_W0   = 10'd1;
    localparam logic [TAP_W-1:0] KERNEL_W1   = 10'd2;
    localparam logic [TAP_W-1:0] KERNEL_W2   = 10'd1;
    localparam logic [TAP_W-1:0] KERNEL_BIAS = 10'd256;

    localparam int TIMEOUT_CYCLES = 64; // Stall limit while busy
    localparam int TIMEOUT_W      = $clog2(TIMEOUT_CYCLES + 1);

    localparam int PIXEL_FIFO_DEPTH  = 4;
    localparam int RESULT_FIFO_DEPTH = 2;

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [2:0]  addr;
        logic [31:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } reg_rsp_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } pixel_beat_t;

    // Packs into one 32-bit register word
    typedef struct packed {
        logic [23:0] sum;     // Accumulated ReLU outputs
        logic [7:0]  windows; // Windows computed this frame
    } cnn_result_t;

    typedef struct packed {
        logic busy;
    } core_status_t;

endpackage

`default_nettype wire
